//--- design/dbus_decode.sv
`default_nettype none

module dbus_decode import soc_bus_pkg::*; (
    input  wire        ck,
    input  wire        RESET_LOOP,
    input  logic       i_dbus_cyc,
    input  dev_code_t  i_dev,
    input  logic       i_ram_ack,
    input  logic       i_gpio_ack,
    input  logic       i_uart_ack,
    input  data_t      i_ram_rdt,
    input  data_t      i_gpio_rdt,
    input  data_t      i_uart_rdt,
    output logic       o_ram_cyc,
    output logic       o_gpio_cyc,
    output logic       o_uart_cyc,
    output logic       o_ack,
    output data_t      o_rdt
);

    logic hit_ram;
    logic hit_gpio;
    logic hit_uart;
    logic unmapped;
    logic unmapped_ack;

    assign hit_ram  = (i_dev == RAM_DEV);
    assign hit_gpio = (i_dev == GPIO_DEV);
    assign hit_uart = (i_dev == UART_DEV);

    // One strobe per device
    assign o_ram_cyc  = i_dbus_cyc && hit_ram;
    assign o_gpio_cyc = i_dbus_cyc && hit_gpio;
    assign o_uart_cyc = i_dbus_cyc && hit_uart;

    assign unmapped = i_dbus_cyc && !(hit_ram || hit_gpio || hit_uart);

    // Nothing answers here, so ack once with zero data
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            unmapped_ack <= 1'b0;
        end else begin
            unmapped_ack <= unmapped && !unmapped_ack;
        end
    end

    // Idle slaves return zero, so a plain OR combines them
    assign o_ack = i_ram_ack | i_gpio_ack | i_uart_ack | unmapped_ack;
    assign o_rdt = i_ram_rdt | i_gpio_rdt | i_uart_rdt;

endmodule

`default_nettype wire

//--- design/dbus_ram.sv
`default_nettype none

module dbus_ram import soc_bus_pkg::*; (
    input  wire         ck,
    input  wire         RESET_LOOP,
    input  logic        i_cyc,
    input  logic        i_we,
    input  ram_index_t  i_index,
    input  sel_t        i_sel,
    input  data_t       i_wdata,
    output logic        o_ack,
    output data_t       o_rdata
);

    data_t mem [RAM_WORDS];

    logic accept;

    // First cycle of a request, before the ack goes out
    assign accept = i_cyc && !o_ack;

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= accept;
        end
    end

    // Byte-lane writes
    always_ff @(posedge ck) begin
        if (accept && i_we) begin
            for (int lane = 0; lane < SEL_W; lane++) begin
                if (i_sel[lane]) begin
                    mem[i_index][lane*8 +: 8] <= i_wdata[lane*8 +: 8];
                end
            end
        end
    end

    // Read word lines up with the ack, zero at all other times
    always_ff @(posedge ck) begin
        if (accept && !i_we) begin
            o_rdata <= mem[i_index];
        end else begin
            o_rdata <= '0;
        end
    end

endmodule

`default_nettype wire

//--- design/gpio_port.sv
`default_nettype none

module gpio_port
    import soc_bus_pkg::*;
    import uart_pkg::*;
(
    input  wire    ck,
    input  wire    RESET_LOOP,
    input  logic   i_cyc,
    input  logic   i_we,
    input  sel_t   i_sel,
    input  data_t  i_wdata,
    output logic   o_ack,
    output data_t  o_rdata,
    output byte_t  o_gpio
);

    logic accept;

    assign accept = i_cyc && !o_ack;

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            o_ack   <= 1'b0;
            o_gpio  <= '0;
            o_rdata <= '0;
        end else begin
            o_ack <= accept;

            // Only byte lane 0 reaches the pins
            if (accept && i_we && i_sel[0]) begin
                o_gpio <= i_wdata[7:0];
            end

            // Readback is zero-extended
            if (accept && !i_we) begin
                o_rdata <= data_t'(o_gpio);
            end else begin
                o_rdata <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/periph_soc.sv
`default_nettype none

module periph_soc
    import soc_bus_pkg::*;
    import uart_pkg::*;
(
    input  wire    ck,
    input  wire    RESET_LOOP,
    input  logic   i_dbus_cyc,
    input  logic   i_dbus_we,
    input  addr_t  i_dbus_adr,
    input  sel_t   i_dbus_sel,
    input  data_t  i_dbus_dat,
    output data_t  o_dbus_rdt,
    output logic   o_dbus_ack,
    output logic   o_tx,
    output byte_t  o_gpio
);

    dev_code_t  dev;
    ram_index_t ram_index;

    assign dev       = i_dbus_adr[31:24];
    assign ram_index = i_dbus_adr[9:2];

    logic  ram_cyc;
    logic  gpio_cyc;
    logic  uart_cyc;
    logic  ram_ack;
    logic  gpio_ack;
    logic  uart_ack;
    data_t ram_rdt;
    data_t gpio_rdt;
    data_t uart_rdt;
    logic  baud_run;
    logic  baud_tick;

    dbus_decode u_decode (
        .ck         (ck),
        .RESET_LOOP (RESET_LOOP),
        .i_dbus_cyc (i_dbus_cyc),
        .i_dev      (dev),
        .i_ram_ack  (ram_ack),
        .i_gpio_ack (gpio_ack),
        .i_uart_ack (uart_ack),
        .i_ram_rdt  (ram_rdt),
        .i_gpio_rdt (gpio_rdt),
        .i_uart_rdt (uart_rdt),
        .o_ram_cyc  (ram_cyc),
        .o_gpio_cyc (gpio_cyc),
        .o_uart_cyc (uart_cyc),
        .o_ack      (o_dbus_ack),
        .o_rdt      (o_dbus_rdt)
    );

    dbus_ram u_ram (
        .ck         (ck),
        .RESET_LOOP (RESET_LOOP),
        .i_cyc      (ram_cyc),
        .i_we       (i_dbus_we),
        .i_index    (ram_index),
        .i_sel      (i_dbus_sel),
        .i_wdata    (i_dbus_dat),
        .o_ack      (ram_ack),
        .o_rdata    (ram_rdt)
    );

    gpio_port u_gpio (
        .ck         (ck),
        .RESET_LOOP (RESET_LOOP),
        .i_cyc      (gpio_cyc),
        .i_we       (i_dbus_we),
        .i_sel      (i_dbus_sel),
        .i_wdata    (i_dbus_dat),
        .o_ack      (gpio_ack),
        .o_rdata    (gpio_rdt),
        .o_gpio     (o_gpio)
    );

    uart_baud_timer u_baud (
        .ck         (ck),
        .RESET_LOOP (RESET_LOOP),
        .i_run      (baud_run),
        .o_tick     (baud_tick)
    );

    uart_tx u_uart (
        .ck          (ck),
        .RESET_LOOP  (RESET_LOOP),
        .i_cyc       (uart_cyc),
        .i_we        (i_dbus_we),
        .i_wdata     (i_dbus_dat),
        .i_baud_tick (baud_tick),
        .o_ack       (uart_ack),
        .o_rdata     (uart_rdt),
        .o_baud_run  (baud_run),
        .o_tx        (o_tx)
    );

endmodule

`default_nettype wire

//--- design/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    // Data bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [SEL_W-1:0]  sel_t;

    // Device field, address bits 31 to 24
    typedef logic [7:0] dev_code_t;

    localparam dev_code_t RAM_DEV  = 8'h00;
    localparam dev_code_t GPIO_DEV = 8'h40;
    localparam dev_code_t UART_DEV = 8'h50;

    // Data RAM, one entry per bus word
    localparam int RAM_WORDS = 256;

    // Word index, address bits 9 to 2
    typedef logic [7:0] ram_index_t;

endpackage

`default_nettype wire

//--- design/uart_baud_timer.sv
`default_nettype none

module uart_baud_timer import uart_pkg::*; (
    input  wire   ck,
    input  wire   RESET_LOOP,
    input  logic  i_run,
    output logic  o_tick
);

    localparam baud_count_t LAST = baud_count_t'(BAUD_DIVIDE - 1);

    baud_count_t count;

    // Held at zero while idle so each frame starts a fresh period
    always_ff @(posedge ck) begin
        if (RESET_LOOP || !i_run) begin
            count <= '0;
        end else if (count == LAST) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Last cycle of each bit period
    assign o_tick = i_run && (count == LAST);

endmodule

`default_nettype wire

//--- design/uart_pkg.sv
`default_nettype none

package uart_pkg;

    typedef logic [7:0] byte_t;

    // Clock cycles per serial bit
    localparam int BAUD_DIVIDE = 8;

    typedef logic [3:0] baud_count_t;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

endpackage

`default_nettype wire

//--- design/uart_tx.sv
`default_nettype none

module uart_tx
    import soc_bus_pkg::*;
    import uart_pkg::*;
(
    input  wire    ck,
    input  wire    RESET_LOOP,
    input  logic   i_cyc,
    input  logic   i_we,
    input  data_t  i_wdata,
    input  logic   i_baud_tick,
    output logic   o_ack,
    output data_t  o_rdata,
    output logic   o_baud_run,
    output logic   o_tx
);

    uart_state_e state;
    byte_t       shift;
    logic [2:0]  bit_cnt;

    logic busy;
    logic accept_rd;
    logic accept_wr;

    assign busy = (state != UART_IDLE);

    // Status reads always go through
    assign accept_rd = i_cyc && !i_we && !o_ack;

    // A write waits here, unacked, until the frame in flight is done
    assign accept_wr = i_cyc && i_we && !o_ack && !busy;

    assign o_baud_run = busy;

    // Bus side
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            o_ack   <= 1'b0;
            o_rdata <= '0;
        end else begin
            o_ack <= accept_rd || accept_wr;
            if (accept_rd) begin
                // Bit 0 is busy
                o_rdata <= data_t'(busy);
            end else begin
                o_rdata <= '0;
            end
        end
    end

    // Frame sequencer
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            state   <= UART_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                UART_IDLE: begin
                    if (accept_wr) begin
                        state   <= UART_START;
                        bit_cnt <= '0;
                    end
                end
                UART_START: begin
                    if (i_baud_tick) begin
                        state <= UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (i_baud_tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= UART_STOP;
                        end
                    end
                end
                UART_STOP: begin
                    if (i_baud_tick) begin
                        state <= UART_IDLE;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    // Byte shifts out LSB first
    always_ff @(posedge ck) begin
        if (accept_wr) begin
            shift <= i_wdata[7:0];
        end else if (state == UART_DATA && i_baud_tick) begin
            shift <= shift >> 1;
        end
    end

    // Line is registered, one cycle behind the state
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            o_tx <= 1'b1;
        end else begin
            case (state)
                UART_START: o_tx <= 1'b0;
                UART_DATA:  o_tx <= shift[0];
                default:    o_tx <= 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- periph_soc.f
design/soc_bus_pkg.sv
design/uart_pkg.sv
design/dbus_decode.sv
design/dbus_ram.sv
design/gpio_port.sv
design/uart_baud_timer.sv
design/uart_tx.sv
design/periph_soc.sv
tb/periph_soc_tb.sv

//--- tb/periph_soc_tb.sv
`default_nettype none

module periph_soc_tb
    import soc_bus_pkg::*;
    import uart_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT   = 1000;
    localparam int FRAME_CYCLES = 10 * BAUD_DIVIDE;

    logic  ck;
    logic  RESET_LOOP;
    logic  dbus_cyc;
    logic  dbus_we;
    addr_t dbus_adr;
    sel_t  dbus_sel;
    data_t dbus_dat;
    data_t dbus_rdt;
    logic  dbus_ack;
    logic  tx;
    byte_t gpio;

    int    errors;
    int    ops;
    byte_t rx_bytes [$];
    data_t ram_model [ram_index_t];

    periph_soc i_dut (
        .ck         (ck),
        .RESET_LOOP (RESET_LOOP),
        .i_dbus_cyc (dbus_cyc),
        .i_dbus_we  (dbus_we),
        .i_dbus_adr (dbus_adr),
        .i_dbus_sel (dbus_sel),
        .i_dbus_dat (dbus_dat),
        .o_dbus_rdt (dbus_rdt),
        .o_dbus_ack (dbus_ack),
        .o_tx       (tx),
        .o_gpio     (gpio)
    );

    always #5 ck = ~ck;

    task automatic report_mismatch(input string name, input data_t expected,
                                   input data_t actual);
        errors++;
        $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                 $time, name, expected, actual);
    endtask

    task automatic abort_run(input string why);
        errors++;
        $display("ERROR at %0t ns: %s", $time, why);
        $display("Ran %0d operations, %0d errors", ops, errors);
        $display("Something failed");
        $finish;
    endtask

    // Expected RAM word after a byte-lane write
    function automatic data_t merge_lanes(input data_t old_word, input data_t new_word,
                                          input sel_t sel);
        data_t merged;
        merged = old_word;
        for (int lane = 0; lane < 4; lane++) begin
            if (sel[lane]) begin
                merged[lane*8 +: 8] = new_word[lane*8 +: 8];
            end
        end
        return merged;
    endfunction

    // One bus cycle
    // Falling edges until ack are counted in waited
    task automatic bus_access(input logic we, input addr_t adr, input sel_t sel,
                              input data_t dat, output data_t rdt, output int waited);
        waited = 0;
        @(posedge ck);
        dbus_cyc <= 1'b1;
        dbus_we  <= we;
        dbus_adr <= adr;
        dbus_sel <= sel;
        dbus_dat <= dat;
        do begin
            @(negedge ck);
            waited++;
        end while (dbus_ack !== 1'b1 && waited < WAIT_LIMIT);
        if (dbus_ack !== 1'b1) begin
            abort_run($sformatf("no bus ack for address %h", adr));
        end
        rdt = dbus_rdt;
        @(posedge ck);
        dbus_cyc <= 1'b0;
        dbus_we  <= 1'b0;
    endtask

    // Serial line monitor
    // Each bit is sampled in its middle
    task automatic receive_byte(output byte_t value);
        int waited;
        waited = 0;
        while (tx === 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge ck);
            waited++;
        end
        if (tx !== 1'b0) begin
            abort_run("no start bit seen on o_tx");
        end
        repeat (BAUD_DIVIDE / 2 - 1) @(negedge ck);
        if (tx !== 1'b0) begin
            report_mismatch("o_tx start bit", 32'd0, 32'(tx));
        end
        for (int i = 0; i < 8; i++) begin
            repeat (BAUD_DIVIDE) @(negedge ck);
            value[i] = tx;
        end
        repeat (BAUD_DIVIDE) @(negedge ck);
        if (tx !== 1'b1) begin
            report_mismatch("o_tx stop bit", 32'd1, 32'(tx));
        end
    endtask

    task automatic check_line_idle(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(negedge ck);
            if (tx !== 1'b1) begin
                report_mismatch("o_tx idle", 32'd1, 32'(tx));
                return;
            end
        end
    endtask

    task automatic run_operation(input byte_t op, input addr_t adr, input sel_t sel,
                                 input data_t dat, input data_t exp);
        data_t got;
        data_t old_word;
        int    waited;
        byte_t first;
        byte_t second;
        case (op)
            "W": begin
                bus_access(1'b1, adr, sel, dat, got, waited);
                if (adr[31:24] == RAM_DEV) begin
                    old_word = ram_model.exists(adr[9:2]) ? ram_model[adr[9:2]] : 'x;
                    ram_model[adr[9:2]] = merge_lanes(old_word, dat, sel);
                end
            end
            "R": begin
                bus_access(1'b0, adr, sel, dat, got, waited);
                if (got !== exp) begin
                    report_mismatch("o_dbus_rdt", exp, got);
                end
                if (adr[31:24] == RAM_DEV && ram_model.exists(adr[9:2])) begin
                    if (got !== ram_model[adr[9:2]]) begin
                        report_mismatch("o_dbus_rdt (RAM model)", ram_model[adr[9:2]], got);
                    end
                end
            end
            "G": begin
                @(negedge ck);
                if (gpio !== exp[7:0]) begin
                    report_mismatch("o_gpio", exp, 32'(gpio));
                end
            end
            "U": begin
                fork
                    begin
                        receive_byte(first);
                        rx_bytes.push_back(first);
                    end
                    begin
                        bus_access(1'b1, adr, sel, dat, got, waited);
                        // Status read lands inside the frame
                        bus_access(1'b0, adr, sel, '0, got, waited);
                        if (got !== 32'd1) begin
                            report_mismatch("o_dbus_rdt (UART status)", 32'd1, got);
                        end
                    end
                join
                first = rx_bytes.pop_front();
                if (first !== exp[7:0]) begin
                    report_mismatch("o_tx byte", 32'(exp[7:0]), 32'(first));
                end
            end
            "Q": begin
                fork
                    begin
                        receive_byte(first);
                        rx_bytes.push_back(first);
                        receive_byte(second);
                        rx_bytes.push_back(second);
                    end
                    begin
                        bus_access(1'b1, adr, sel, {24'h0, dat[7:0]}, got, waited);
                        bus_access(1'b1, adr, sel, {24'h0, dat[15:8]}, got, waited);
                        // Second ack is held back for the whole first frame
                        if (waited < FRAME_CYCLES - 2) begin
                            report_mismatch("o_dbus_ack wait cycles",
                                            FRAME_CYCLES - 2, waited);
                        end
                    end
                join
                first  = rx_bytes.pop_front();
                second = rx_bytes.pop_front();
                if (first !== exp[7:0]) begin
                    report_mismatch("o_tx first byte", 32'(exp[7:0]), 32'(first));
                end
                if (second !== exp[15:8]) begin
                    report_mismatch("o_tx second byte", 32'(exp[15:8]), 32'(second));
                end
                check_line_idle(2 * FRAME_CYCLES);
            end
            default: abort_run("unknown operation letter in the test file");
        endcase
    endtask

    initial begin
        int    fd;
        int    c;
        int    n;
        addr_t adr;
        sel_t  sel;
        data_t dat;
        data_t exp;

        ck         = 1'b0;
        RESET_LOOP = 1'b1;
        dbus_cyc   = 1'b0;
        dbus_we    = 1'b0;
        dbus_adr   = '0;
        dbus_sel   = '0;
        dbus_dat   = '0;
        errors     = 0;
        ops        = 0;

        fd = $fopen("tb/periph_soc_tests.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tb/periph_soc_tests.txt");
        end

        repeat (10) @(posedge ck);
        RESET_LOOP <= 1'b0;

        // Idle values out of reset
        @(negedge ck);
        if (dbus_ack !== 1'b0) begin
            report_mismatch("o_dbus_ack", 32'd0, 32'(dbus_ack));
        end
        if (tx !== 1'b1) begin
            report_mismatch("o_tx", 32'd1, 32'(tx));
        end
        if (gpio !== 8'h00) begin
            report_mismatch("o_gpio", 32'd0, 32'(gpio));
        end

        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
                n = $fscanf(fd, "%h %h %h %h", adr, sel, dat, exp);
                if (n != 4) begin
                    abort_run("malformed line in the test file");
                end
                ops++;
                run_operation(byte_t'(c), adr, sel, dat, exp);
            end
            c = $fgetc(fd);
        end
        $fclose(fd);

        $display("Ran %0d operations, %0d errors", ops, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/periph_soc_tests.txt
# op address sel data expected (hex)
# W write, R read, G check pins, U one UART byte, Q UART bytes data[7:0] then data[15:8]
W 00000010 F 12345678 00000000
R 00000010 F 00000000 12345678
W 00000010 5 AABBCCDD 00000000
R 00000010 F 00000000 12BB56DD
W 000003FC F DEADBEEF 00000000
R 000003FC F 00000000 DEADBEEF
W 00000020 F 00000000 00000000
W 00000020 A 11223344 00000000
R 00000020 F 00000000 11003300
G 00000000 0 00000000 00000000
W 40000000 1 000000A5 00000000
G 00000000 0 00000000 000000A5
R 40000000 F 00000000 000000A5
W 40000000 E 0000005A 00000000
G 00000000 0 00000000 000000A5
U 50000000 1 00000053 00000053
Q 50000000 1 0000C33C 0000C33C
R 50000000 F 00000000 00000000
R 90000000 F 00000000 00000000
R 00000010 F 00000000 12BB56DD
